//--- Bender.yml
package:
  name: edge_reader

sources:
  - include_dirs:
      - include
    files:
      - verilog/edge_reader_pkg.sv
      - verilog/vertex_if.sv
      - verilog/vertex_fifo.sv
      - verilog/cacheline_splitter.sv
      - verilog/edge_reader_lane.sv
      - verilog/vertex_dispatcher.sv
      - verilog/iteration_end_detector.sv
      - verilog/edge_reader_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/edge_reader_checker.sv
      - sim/edge_reader_tb.sv

//--- compile.f
+incdir+include
verilog/edge_reader_pkg.sv
verilog/vertex_if.sv
verilog/vertex_fifo.sv
verilog/cacheline_splitter.sv
verilog/edge_reader_lane.sv
verilog/vertex_dispatcher.sv
verilog/iteration_end_detector.sv
verilog/edge_reader_top.sv
sim/edge_reader_checker.sv
sim/edge_reader_tb.sv

//--- include/edge_reader_config.svh
`ifndef EDGE_READER_CONFIG_SVH
`define EDGE_READER_CONFIG_SVH

// lanes, one per core
`define CORE_NUM 4

`define V_ID_WIDTH 16
`define OFFSET_WIDTH 22

// 8 edges per cacheline
`define CACHELINE_LEN_WIDTH 3

// lane FIFO depth 4, full reported at 3 so a staged write still fits
`define FIFO_AWIDTH 2
`define FIFO_PROG_FULL 3

// settled cycles before iteration end is reported
`define WAIT_END_DELAY 20

`endif

//--- sim/edge_reader_checker.sv
`timescale 1ns/1ps

module edge_reader_checker import edge_reader_pkg::*; (
    input logic                          clk,
    input logic                          rst,
    input logic       [CORE_NUM-1:0]     edge_stall,
    input edge_mask_t [CORE_NUM-1:0]     edge_mask,
    input logic       [CORE_NUM-1:0]     edge_valid,
    input logic                          iteration_end
);

    int unsigned fail_count = 0;

    for (genvar i = 0; i < CORE_NUM; i++) begin : g_lane
        a_mask_nonzero: assert property (@(posedge clk) disable iff (rst)
            edge_valid[i] |-> edge_mask[i] != '0)
            else begin
                fail_count++;
                $error("lane %0d issued a request with an empty mask", i);
            end

        // nothing issued in a stalled cycle
        a_stall_hold: assert property (@(posedge clk) disable iff (rst)
            edge_stall[i] |=> !edge_valid[i])
            else begin
                fail_count++;
                $error("lane %0d issued a request while stalled", i);
            end
    end

    a_end_quiet: assert property (@(posedge clk) disable iff (rst)
        iteration_end |-> edge_valid == '0)
        else begin
            fail_count++;
            $error("iteration end reported while requests are still coming out");
        end

endmodule

bind edge_reader_top edge_reader_checker u_checker (.*);

//--- sim/edge_reader_tb.sv
`timescale 1ns/1ps

`include "edge_reader_config.svh"

module edge_reader_tb import edge_reader_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic clk = 1'b0;
    logic rst;
    vertex_id_t in_v_id;
    offset_t in_loffset;
    offset_t in_roffset;
    logic in_valid;
    logic in_ready;
    logic front_iteration_end;
    logic [`CORE_NUM-1:0] edge_stall;
    line_addr_t [`CORE_NUM-1:0] edge_addr;
    edge_mask_t [`CORE_NUM-1:0] edge_mask;
    vertex_id_t [`CORE_NUM-1:0] edge_v_id;
    logic [`CORE_NUM-1:0] edge_valid;
    logic iteration_end;

    // expected requests in one queue per lane
    edge_req_t exp_q [`CORE_NUM][$];
    integer seed = 78239;
    int cycle = 0;
    int last_valid_cycle = 0;

    edge_reader_top UUT (.*);

    always #4 clk = ~clk;

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "stopping on first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s never happened", $time, what);
        $display("Something failed");
        $fatal(1, "stopping on timeout");
    endtask

    function automatic edge_mask_t line_mask(input int unsigned line, input int unsigned l,
                                             input int unsigned r);
        edge_mask_t m;
        int unsigned e;
        for (int i = 0; i < (1 << `CACHELINE_LEN_WIDTH); i++) begin
            e = (line << `CACHELINE_LEN_WIDTH) + i;
            m[i] = (e >= l) && (e < r);
        end
        return m;
    endfunction

    // one request per touched line, in increasing line order
    task automatic add_expected(input vertex_id_t v, input int unsigned l, input int unsigned r);
        int lane;
        edge_req_t req;
        lane = v % `CORE_NUM;
        if (l < r) begin
            for (int unsigned k = l >> `CACHELINE_LEN_WIDTH;
                 k <= (r - 1) >> `CACHELINE_LEN_WIDTH; k++) begin
                req.addr = line_addr_t'(k);
                req.mask = line_mask(k, l, r);
                req.v_id = v;
                exp_q[lane].push_back(req);
            end
        end
    endtask

    // called on a falling edge and returns on the falling edge after acceptance
    task automatic send_vertex(input vertex_id_t v, input int unsigned l, input int unsigned r);
        int waited;
        waited = 0;
        in_v_id = v;
        in_loffset = offset_t'(l);
        in_roffset = offset_t'(r);
        in_valid = 1'b1;
        while (!in_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                report_timeout("in_ready for a new vertex");
        end
        add_expected(v, l, r);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_lane_drained(input int lane);
        int waited;
        waited = 0;
        while (exp_q[lane].size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                report_timeout($sformatf("all requests on lane %0d", lane));
        end
    endtask

    task automatic wait_drained();
        for (int i = 0; i < `CORE_NUM; i++)
            wait_lane_drained(i);
    endtask

    task automatic wait_end_level(input logic level);
        int waited;
        waited = 0;
        while (iteration_end !== level) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                report_timeout($sformatf("iteration_end going to %0d", level));
        end
    endtask

    always @(posedge clk) begin
        edge_req_t exp;
        if (!rst) begin
            for (int i = 0; i < `CORE_NUM; i++) begin
                if (edge_valid[i]) begin
                    last_valid_cycle = cycle;
                    if (exp_q[i].size() == 0) begin
                        $display("unexpected request on lane %0d at %0t", i, $time);
                        $display("Something failed");
                        $fatal(1, "stopping on extra request");
                    end
                    exp = exp_q[i].pop_front();
                    check_value($sformatf("lane %0d addr", i), edge_addr[i], exp.addr);
                    check_value($sformatf("lane %0d mask", i), edge_mask[i], exp.mask);
                    check_value($sformatf("lane %0d v_id", i), edge_v_id[i], exp.v_id);
                end
            end
        end
        cycle = cycle + 1;
    end

    task automatic test_reset_state();
        check_value("edge_valid after reset", edge_valid, '0);
        check_value("iteration_end after reset", iteration_end, 1'b0);
        check_value("in_ready after reset", in_ready, 1'b1);
    endtask

    task automatic test_single_line();
        send_vertex(16'h0005, 10, 14);
        wait_drained();
    endtask

    task automatic test_multi_line();
        send_vertex(16'h0006, 13, 37);
        // a zero-length vertex must not hold up the next one
        send_vertex(16'h000a, 20, 20);
        send_vertex(16'h000e, 40, 43);
        wait_drained();
    endtask

    task automatic test_stall();
        int waited;
        edge_stall = 4'b1000;
        send_vertex(16'h0010, 64, 80);
        for (int j = 0; j < 5; j++)
            send_vertex(16'h0003 + 4 * j, 200 + 13 * j, 211 + 13 * j);
        waited = 0;
        while (in_ready) begin
            check_value("stalled lane valid", edge_valid[3], 1'b0);
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
                report_timeout("in_ready falling on a full lane");
        end
        wait_lane_drained(0);
        // hold the stall with the input blocked
        for (int j = 0; j < 10; j++) begin
            check_value("stalled lane valid", edge_valid[3], 1'b0);
            check_value("in_ready on a full lane", in_ready, 1'b0);
            @(negedge clk);
        end
        edge_stall = '0;
        wait_drained();
    endtask

    task automatic test_random();
        int unsigned l;
        int unsigned len;
        for (int j = 0; j < 40; j++) begin
            l = {$random(seed)} % 4000000;
            len = {$random(seed)} % 30;
            send_vertex(vertex_id_t'($random(seed)), l, l + len);
        end
        wait_drained();
    endtask

    task automatic test_iteration_end();
        int total;
        front_iteration_end = 1'b1;
        send_vertex(16'h0021, 300, 330);
        wait_end_level(1'b1);
        total = 0;
        for (int i = 0; i < `CORE_NUM; i++)
            total += exp_q[i].size();
        check_value("requests left at iteration end", total, 0);
        check_value("settle delay reached", (cycle - last_valid_cycle) >= `WAIT_END_DELAY, 1);
        front_iteration_end = 1'b0;
        wait_end_level(1'b0);
    endtask

    initial begin
        rst = 1'b1;
        in_v_id = '0;
        in_loffset = '0;
        in_roffset = '0;
        in_valid = 1'b0;
        front_iteration_end = 1'b0;
        edge_stall = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_single_line();
        test_multi_line();
        test_stall();
        test_random();
        test_iteration_end();
        if (UUT.u_checker.fail_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- verilog/cacheline_splitter.sv
`timescale 1ns/1ps

module cacheline_splitter import edge_reader_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  vertex_id_t head_v_id,
    input  offset_t    head_loffset,
    input  offset_t    head_roffset,
    input  logic       head_present,
    output logic       pop,
    input  logic       stall,
    output edge_req_t  req,
    output logic       req_valid,
    output logic       idle
);

    split_state_e state;
    line_addr_t cur_line;

    line_addr_t first_line;
    line_addr_t last_line;
    line_addr_t line;
    offset_t last_edge;
    edge_mask_t mask;
    logic empty_range;
    logic last;
    logic issue;

    assign empty_range = (head_loffset >= head_roffset);
    assign last_edge = head_roffset - 1'b1;
    assign first_line = head_loffset[$bits(offset_t)-1:CACHELINE_LEN_WIDTH];
    assign last_line = last_edge[$bits(offset_t)-1:CACHELINE_LEN_WIDTH];

    // first line comes straight from the head, later ones from the walk register
    assign line = (state == split_walk) ? cur_line : first_line;
    assign last = (line == last_line);

    assign issue = head_present && !stall && !empty_range;

    // an empty range is dropped without waiting on the stall
    assign pop = head_present && (empty_range || (!stall && last));

    always_comb begin
        offset_t slot;
        for (int i = 0; i < CACHELINE_LEN; i++) begin
            slot = {line, CACHELINE_LEN_WIDTH'(i)};
            mask[i] = (slot >= head_loffset) && (slot < head_roffset);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= split_idle;
            req_valid <= 1'b0;
        end else begin
            req_valid <= issue;
            case (state)
                split_idle: begin
                    if (issue && !last)
                        state <= split_walk;
                end
                split_walk: begin
                    if (issue && last)
                        state <= split_idle;
                end
                default: state <= split_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req <= '{addr: line, mask: mask, v_id: head_v_id};
            cur_line <= line + 1'b1;
        end
    end

    assign idle = (state == split_idle) && !head_present && !req_valid;

endmodule

//--- verilog/edge_reader_lane.sv
`timescale 1ns/1ps

module edge_reader_lane import edge_reader_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    vertex_if.lane    vin,
    input  logic      stall,
    output edge_req_t req,
    output logic      req_valid,
    output logic      idle
);

    vertex_id_t head_v_id;
    offset_t head_loffset;
    offset_t head_roffset;
    logic fifo_empty;
    logic pop;
    logic split_idle_flag;

    vertex_fifo u_fifo (
        .clk          (clk),
        .rst          (rst),
        .din_v_id     (vin.v_id),
        .din_loffset  (vin.loffset),
        .din_roffset  (vin.roffset),
        .wr_en        (vin.valid),
        .rd_en        (pop),
        .dout_v_id    (head_v_id),
        .dout_loffset (head_loffset),
        .dout_roffset (head_roffset),
        .empty        (fifo_empty),
        .prog_full    (vin.full)
    );

    cacheline_splitter u_splitter (
        .clk          (clk),
        .rst          (rst),
        .head_v_id    (head_v_id),
        .head_loffset (head_loffset),
        .head_roffset (head_roffset),
        .head_present (!fifo_empty),
        .pop          (pop),
        .stall        (stall),
        .req          (req),
        .req_valid    (req_valid),
        .idle         (split_idle_flag)
    );

    // a write landing this cycle keeps the lane busy
    assign idle = split_idle_flag && !vin.valid;

endmodule

//--- verilog/edge_reader_pkg.sv
`include "edge_reader_config.svh"

package edge_reader_pkg;

    localparam int CORE_NUM = `CORE_NUM;
    localparam int CACHELINE_LEN_WIDTH = `CACHELINE_LEN_WIDTH;
    localparam int CACHELINE_LEN = 1 << CACHELINE_LEN_WIDTH;
    localparam int FIFO_AWIDTH = `FIFO_AWIDTH;
    localparam int FIFO_PROG_FULL = `FIFO_PROG_FULL;
    localparam int WAIT_END_DELAY = `WAIT_END_DELAY;

    typedef logic [`V_ID_WIDTH-1:0] vertex_id_t;
    typedef logic [`OFFSET_WIDTH-1:0] offset_t;
    // offset without the slot bits
    typedef logic [`OFFSET_WIDTH-CACHELINE_LEN_WIDTH-1:0] line_addr_t;
    typedef logic [CACHELINE_LEN-1:0] edge_mask_t;
    typedef logic [$clog2(CORE_NUM)-1:0] lane_idx_t;

    typedef struct packed {
        line_addr_t addr;
        edge_mask_t mask;
        vertex_id_t v_id;
    } edge_req_t;

    typedef enum logic {
        split_idle,
        split_walk
    } split_state_e;

endpackage

//--- verilog/edge_reader_top.sv
`timescale 1ns/1ps

`include "edge_reader_config.svh"

module edge_reader_top import edge_reader_pkg::*; (
    input  logic                           clk,
    input  logic                           rst,
    input  vertex_id_t                     in_v_id,
    input  offset_t                        in_loffset,
    input  offset_t                        in_roffset,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic                           front_iteration_end,
    input  logic       [`CORE_NUM-1:0]     edge_stall,
    output line_addr_t [`CORE_NUM-1:0]     edge_addr,
    output edge_mask_t [`CORE_NUM-1:0]     edge_mask,
    output vertex_id_t [`CORE_NUM-1:0]     edge_v_id,
    output logic       [`CORE_NUM-1:0]     edge_valid,
    output logic                           iteration_end
);

    vertex_if lane_bus [CORE_NUM] ();

    edge_req_t lane_req [CORE_NUM];
    logic [CORE_NUM-1:0] lane_idle;
    logic dispatch_empty;

    vertex_dispatcher u_dispatcher (
        .clk        (clk),
        .rst        (rst),
        .in_v_id    (in_v_id),
        .in_loffset (in_loffset),
        .in_roffset (in_roffset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .lanes      (lane_bus),
        .empty      (dispatch_empty)
    );

    for (genvar g = 0; g < CORE_NUM; g++) begin : g_core
        edge_reader_lane u_lane (
            .clk       (clk),
            .rst       (rst),
            .vin       (lane_bus[g]),
            .stall     (edge_stall[g]),
            .req       (lane_req[g]),
            .req_valid (edge_valid[g]),
            .idle      (lane_idle[g])
        );

        assign edge_addr[g] = lane_req[g].addr;
        assign edge_mask[g] = lane_req[g].mask;
        assign edge_v_id[g] = lane_req[g].v_id;
    end

    iteration_end_detector u_end_detector (
        .clk                 (clk),
        .rst                 (rst),
        .front_iteration_end (front_iteration_end),
        .dispatch_empty      (dispatch_empty),
        .lane_idle           (lane_idle),
        .iteration_end       (iteration_end)
    );

endmodule

//--- verilog/iteration_end_detector.sv
`timescale 1ns/1ps

module iteration_end_detector import edge_reader_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                front_iteration_end,
    input  logic                dispatch_empty,
    input  logic [CORE_NUM-1:0] lane_idle,
    output logic                iteration_end
);

    localparam int CNT_W = $clog2(WAIT_END_DELAY + 1);

    logic [CNT_W-1:0] settle_cnt;
    logic settled;

    assign settled = front_iteration_end && dispatch_empty && (&lane_idle);

    always_ff @(posedge clk) begin
        if (rst || !settled) begin
            settle_cnt <= '0;
            iteration_end <= 1'b0;
        end else if (settle_cnt >= WAIT_END_DELAY) begin
            iteration_end <= 1'b1;
        end else begin
            // still settling
            settle_cnt <= settle_cnt + 1'b1;
            iteration_end <= 1'b0;
        end
    end

endmodule

//--- verilog/vertex_dispatcher.sv
`timescale 1ns/1ps

module vertex_dispatcher import edge_reader_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  vertex_id_t   in_v_id,
    input  offset_t      in_loffset,
    input  offset_t      in_roffset,
    input  logic         in_valid,
    output logic         in_ready,
    vertex_if.dispatcher lanes [CORE_NUM],
    output logic         empty
);

    vertex_id_t stage_v_id;
    offset_t stage_loffset;
    offset_t stage_roffset;
    logic stage_valid;
    lane_idx_t stage_lane;

    logic [CORE_NUM-1:0] lane_full;
    logic [CORE_NUM-1:0] lane_full_q;
    logic send;
    logic accept;

    for (genvar i = 0; i < CORE_NUM; i++) begin : g_lane
        assign lane_full[i] = lanes[i].full;
        assign lanes[i].valid = send && (stage_lane == lane_idx_t'(i));
        assign lanes[i].v_id = stage_v_id;
        assign lanes[i].loffset = stage_loffset;
        assign lanes[i].roffset = stage_roffset;
    end

    // low id bits pick the core
    assign stage_lane = stage_v_id[$bits(lane_idx_t)-1:0];

    // full from the previous cycle, the spare FIFO slot covers the lag
    assign send = stage_valid && !lane_full_q[stage_lane];
    assign in_ready = !stage_valid || !lane_full_q[stage_lane];
    assign accept = in_valid && in_ready;
    assign empty = !stage_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
            lane_full_q <= '0;
        end else begin
            lane_full_q <= lane_full;
            if (accept)
                stage_valid <= 1'b1;
            else if (send)
                stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_v_id <= in_v_id;
            stage_loffset <= in_loffset;
            stage_roffset <= in_roffset;
        end
    end

endmodule

//--- verilog/vertex_fifo.sv
`timescale 1ns/1ps

module vertex_fifo import edge_reader_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  vertex_id_t din_v_id,
    input  offset_t    din_loffset,
    input  offset_t    din_roffset,
    input  logic       wr_en,
    input  logic       rd_en,
    output vertex_id_t dout_v_id,
    output offset_t    dout_loffset,
    output offset_t    dout_roffset,
    output logic       empty,
    output logic       prog_full
);

    localparam int DEPTH = 1 << FIFO_AWIDTH;

    vertex_id_t mem_v_id [DEPTH];
    offset_t mem_loffset [DEPTH];
    offset_t mem_roffset [DEPTH];

    logic [FIFO_AWIDTH-1:0] wr_ptr;
    logic [FIFO_AWIDTH-1:0] rd_ptr;
    logic [FIFO_AWIDTH:0] count;
    logic do_wr;
    logic do_rd;

    assign do_wr = wr_en && (count != DEPTH);
    assign do_rd = rd_en && (count != 0);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_v_id[wr_ptr] <= din_v_id;
            mem_loffset[wr_ptr] <= din_loffset;
            mem_roffset[wr_ptr] <= din_roffset;
        end
    end

    // head is always presented, no read latency
    assign dout_v_id = mem_v_id[rd_ptr];
    assign dout_loffset = mem_loffset[rd_ptr];
    assign dout_roffset = mem_roffset[rd_ptr];

    assign empty = (count == 0);
    assign prog_full = (count >= FIFO_PROG_FULL);

endmodule

//--- verilog/vertex_if.sv
`timescale 1ns/1ps

// one vertex from the dispatcher into a lane FIFO
interface vertex_if import edge_reader_pkg::*; ();

    vertex_id_t v_id;
    offset_t loffset;
    offset_t roffset;
    logic valid;
    logic full;

    modport dispatcher (
        output v_id,
        output loffset,
        output roffset,
        output valid,
        input  full
    );

    modport lane (
        input  v_id,
        input  loffset,
        input  roffset,
        input  valid,
        output full
    );

endinterface
